// File: verilog/leaf_pkg.sv
package leaf_pkg;

    // **************************************************
    // Packet and field widths
    // **************************************************
    localparam int PACKET_BITS  = 49;
    localparam int PAYLOAD_BITS = 32;
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int ADDR_BITS    = 7;

    typedef logic [PAYLOAD_BITS-1:0] payload_t;
    typedef logic [LEAF_BITS-1:0]    leaf_addr_t;
    typedef logic [PORT_BITS-1:0]    port_t;
    typedef logic [ADDR_BITS-1:0]    bram_addr_t;

    // **************************************************
    // Leaf identity and buffer sizing
    // **************************************************
    localparam leaf_addr_t LEAF_ID     = 5'd3;
    localparam port_t      CONFIG_PORT = 4'd0; // Sets the result destination.
    localparam port_t      DATA_PORT   = 4'd1; // Carries one word for the kernel.

    localparam int FIFO_DEPTH    = 16;
    localparam int FIFO_PTR_BITS = 4;

    // Tree packet, most significant field first.
    typedef struct packed {
        logic       valid;
        leaf_addr_t dest_leaf;
        port_t      dest_port;
        bram_addr_t addr;
        payload_t   payload;
    } leaf_packet_t;

    typedef struct packed {
        leaf_addr_t dest_leaf;
        port_t      dest_port;
    } route_t;

    typedef enum logic [1:0] {
        KERNEL_IDLE,
        KERNEL_TAKE,
        KERNEL_SEND
    } kernel_state_t;

endpackage

// File: verilog/packet_receiver.sv
`timescale 1ns/1ps

module packet_receiver (
    input  logic                   clk,
    input  logic                   reset,
    input  leaf_pkg::leaf_packet_t din_bft,
    output logic                   wr_en,
    output leaf_pkg::payload_t     wr_data,
    output leaf_pkg::route_t       route
);

    logic for_me;
    logic is_config;
    logic is_data;

    // **************************************************
    // Address decode
    // **************************************************
    // Only valid packets aimed at this leaf are looked at; the port then
    // tells configuration from data.
    assign for_me    = din_bft.valid && (din_bft.dest_leaf == leaf_pkg::LEAF_ID);
    assign is_config = for_me && (din_bft.dest_port == leaf_pkg::CONFIG_PORT);
    assign is_data   = for_me && (din_bft.dest_port == leaf_pkg::DATA_PORT);

    // **************************************************
    // Destination register
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            route <= '0;
        end else if (is_config) begin
            route.dest_leaf <= din_bft.payload[8:4];
            route.dest_port <= din_bft.payload[3:0];
        end
    end

    // **************************************************
    // Buffer write
    // **************************************************
    // The tree gives a one-cycle strobe, so the write is a single pulse.
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= is_data;
        end
    end

    always_ff @(posedge clk) begin
        if (is_data) begin
            wr_data <= din_bft.payload; // Only sampled when wr_en rises.
        end
    end

endmodule

// File: verilog/payload_fifo.sv
`timescale 1ns/1ps

module payload_fifo (
    input  logic               clk,
    input  logic               reset,
    input  logic               wr_en,
    input  leaf_pkg::payload_t wr_data,
    output leaf_pkg::payload_t rd_data,
    output logic               rd_vld,
    input  logic               rd_ack
);

    leaf_pkg::payload_t mem [leaf_pkg::FIFO_DEPTH];

    logic [leaf_pkg::FIFO_PTR_BITS-1:0] wr_ptr;
    logic [leaf_pkg::FIFO_PTR_BITS-1:0] rd_ptr;
    logic [leaf_pkg::FIFO_PTR_BITS:0]   count;
    logic                               full;
    logic                               push;
    logic                               pop;

    // The depth is a power of two, so the top count bit marks full.
    assign full = count[leaf_pkg::FIFO_PTR_BITS];
    assign push = wr_en && !full; // A write to a full buffer is lost.
    assign pop  = rd_vld && rd_ack;

    assign rd_vld  = (count != '0);
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone.
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: verilog/user_kernel.sv
`timescale 1ns/1ps

module user_kernel (
    input  logic               clk,
    input  logic               reset,
    input  logic               ap_start,
    input  leaf_pkg::payload_t in_data,
    input  logic               in_vld,
    output logic               in_ack,
    output leaf_pkg::payload_t out_data,
    output logic               out_vld,
    input  logic               out_ack
);

    leaf_pkg::kernel_state_t state;
    leaf_pkg::payload_t      sum;
    logic                    started;

    // **************************************************
    // Handshakes
    // **************************************************
    // Leaving TAKE on the ack edge keeps the ack to a single cycle.
    assign in_ack = (state == leaf_pkg::KERNEL_TAKE) && in_vld;

    assign out_vld  = (state == leaf_pkg::KERNEL_SEND);
    assign out_data = sum; // Only changes in TAKE, so stable while offered.

    // **************************************************
    // Control and running sum
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= leaf_pkg::KERNEL_IDLE;
            sum     <= '0;
            started <= 1'b0;
        end else begin
            if (ap_start) begin
                started <= 1'b1; // Kept until the next reset.
            end

            case (state)
                leaf_pkg::KERNEL_IDLE: begin
                    if (started) begin
                        state <= leaf_pkg::KERNEL_TAKE;
                    end
                end
                leaf_pkg::KERNEL_TAKE: begin
                    if (in_ack) begin
                        sum   <= sum + in_data; // Wraps at 32 bits.
                        state <= leaf_pkg::KERNEL_SEND;
                    end
                end
                leaf_pkg::KERNEL_SEND: begin
                    if (out_ack) begin
                        state <= leaf_pkg::KERNEL_TAKE;
                    end
                end
                default: state <= leaf_pkg::KERNEL_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/packet_sender.sv
`timescale 1ns/1ps

module packet_sender (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   resend,
    input  leaf_pkg::route_t       route,
    input  leaf_pkg::payload_t     res_data,
    input  logic                   res_vld,
    output logic                   res_ack,
    output leaf_pkg::leaf_packet_t dout_bft
);

    leaf_pkg::leaf_packet_t pkt_q;
    leaf_pkg::bram_addr_t   addr_cnt;

    // A new result is taken only when the output register is empty and
    // the tree is not asking for a resend.
    assign res_ack = res_vld && !resend && !pkt_q.valid;

    // The tree sees nothing at all while resend is high.
    assign dout_bft = resend ? leaf_pkg::leaf_packet_t'({leaf_pkg::PACKET_BITS{1'b0}})
                             : pkt_q;

    // **************************************************
    // Output register
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            pkt_q.valid <= 1'b0;
            addr_cnt    <= '0;
        end else if (res_ack) begin
            pkt_q <= '{
                valid:     1'b1,
                dest_leaf: route.dest_leaf,
                dest_port: route.dest_port,
                addr:      addr_cnt,
                payload:   res_data
            };
            addr_cnt <= addr_cnt + 1'b1; // Wraps at 128.
        end else if (!resend) begin
            // The packet was on the output this cycle, so it has gone out.
            pkt_q.valid <= 1'b0;
        end
    end

endmodule

// File: verilog/leaf_node.sv
`timescale 1ns/1ps

module leaf_node (
    input  logic                   clk,
    input  logic                   reset,
    input  leaf_pkg::leaf_packet_t din_bft,
    output leaf_pkg::leaf_packet_t dout_bft,
    input  logic                   resend,
    input  logic                   ap_start
);

    logic               wr_en;
    leaf_pkg::payload_t wr_data;
    leaf_pkg::route_t   route;

    leaf_pkg::payload_t fifo_data;
    logic               fifo_vld;
    logic               fifo_ack;

    leaf_pkg::payload_t res_data;
    logic               res_vld;
    logic               res_ack;

    // **************************************************
    // Tree side in
    // **************************************************
    packet_receiver u_packet_receiver (
        .clk     (clk),
        .reset   (reset),
        .din_bft (din_bft),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .route   (route)
    );

    payload_fifo u_payload_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_data (fifo_data),
        .rd_vld  (fifo_vld),
        .rd_ack  (fifo_ack)
    );

    // **************************************************
    // Kernel and tree side out
    // **************************************************
    user_kernel u_user_kernel (
        .clk      (clk),
        .reset    (reset),
        .ap_start (ap_start),
        .in_data  (fifo_data),
        .in_vld   (fifo_vld),
        .in_ack   (fifo_ack),
        .out_data (res_data),
        .out_vld  (res_vld),
        .out_ack  (res_ack)
    );

    packet_sender u_packet_sender (
        .clk      (clk),
        .reset    (reset),
        .resend   (resend),
        .route    (route),
        .res_data (res_data),
        .res_vld  (res_vld),
        .res_ack  (res_ack),
        .dout_bft (dout_bft)
    );

endmodule

// File: bench/leaf_node_assert.sv
`timescale 1ns/1ps

module leaf_node_assert (
    input logic                   clk,
    input logic                   reset,
    input logic                   resend,
    input leaf_pkg::leaf_packet_t dout_bft,
    input leaf_pkg::payload_t     out_data,
    input logic                   out_vld,
    input logic                   out_ack
);

    // **************************************************
    // Tree output and kernel result handshake
    // **************************************************
    blank_on_resend: assert property (@(posedge clk) disable iff (reset)
        resend |-> (dout_bft == '0))
        else $error("dout_bft is not zero while resend is high.");

    single_cycle_valid: assert property (@(posedge clk) disable iff (reset)
        dout_bft.valid |=> !dout_bft.valid)
        else $error("dout_bft valid lasted two cycles.");

    // The result stays offered and unchanged until the sender takes it.
    result_held: assert property (@(posedge clk) disable iff (reset)
        (out_vld && !out_ack) |=> (out_vld && $stable(out_data)))
        else $error("Kernel result changed before it was acked.");

endmodule

bind leaf_node leaf_node_assert u_leaf_node_assert (
    .clk      (clk),
    .reset    (reset),
    .resend   (resend),
    .dout_bft (dout_bft),
    .out_data (res_data),
    .out_vld  (res_vld),
    .out_ack  (res_ack)
);

// File: bench/leaf_node_tb.sv
`timescale 1ns/1ps

module leaf_node_tb;

    logic                   clk;
    logic                   reset;
    leaf_pkg::leaf_packet_t din_bft;
    leaf_pkg::leaf_packet_t dout_bft;
    logic                   resend;
    logic                   ap_start;

    logic [8*12-1:0]        case_op  [64];
    logic [31:0]            case_val [64];
    int                     case_count;
    int                     cycle_count;
    int                     cycle_limit;
    leaf_pkg::leaf_packet_t out_q [$]; // Every packet seen on dout_bft.
    leaf_pkg::payload_t     word_q [$]; // Words sent, in the order the kernel takes them.
    leaf_pkg::payload_t     ref_sum;
    leaf_pkg::route_t       exp_route;
    leaf_pkg::bram_addr_t   exp_addr;
    logic [31:0]            lfsr_state;

    leaf_node u_leaf_node (
        .clk      (clk),
        .reset    (reset),
        .din_bft  (din_bft),
        .dout_bft (dout_bft),
        .resend   (resend),
        .ap_start (ap_start)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (!reset && dout_bft.valid) begin
            out_q.push_back(dout_bft);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, an expected output never came.", cycle_count);
            $display(">>> FAIL");
            $fatal(1, "Timeout");
        end
    end

    // **************************************************
    // Helpers
    // **************************************************
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic random_word(output leaf_pkg::payload_t word);
        word = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // One step per bit taken.
            word = {word[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic send_packet(input logic valid, input leaf_pkg::leaf_addr_t leaf,
                               input leaf_pkg::port_t port, input leaf_pkg::payload_t word);
        @(posedge clk);
        din_bft <= '{valid: valid, dest_leaf: leaf, dest_port: port, addr: 7'd0, payload: word};
        @(posedge clk);
        din_bft <= '0; // One packet is a one-cycle strobe.
    endtask

    task automatic pop_word(output leaf_pkg::payload_t word);
        if (word_q.size() == 0) begin
            $display("The case file expects a sum for a word that was never sent.");
            $display(">>> FAIL");
            $fatal(1, "Word queue empty");
        end
        word = word_q.pop_front();
    endtask

    task automatic check_next_output(input leaf_pkg::payload_t exp_sum);
        leaf_pkg::leaf_packet_t pkt;
        while (out_q.size() == 0) begin
            @(posedge clk);
        end
        pkt = out_q.pop_front();
        check_value("dout_bft.payload", pkt.payload, exp_sum);
        check_value("dout_bft.dest_leaf", 32'(pkt.dest_leaf), 32'(exp_route.dest_leaf));
        check_value("dout_bft.dest_port", 32'(pkt.dest_port), 32'(exp_route.dest_port));
        check_value("dout_bft.addr", 32'(pkt.addr), 32'(exp_addr));
        exp_addr = exp_addr + 7'd1;
    endtask

    // **************************************************
    // Case file
    // **************************************************
    task automatic read_cases();
        int              fd;
        int              n;
        string           line;
        logic [8*12-1:0] op;
        logic [31:0]     val;
        fd = $fopen("bench/leaf_node_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/leaf_node_cases.txt.");
            $display(">>> FAIL");
            $fatal(1, "No case file");
        end
        case_count = 0;
        while ($fgets(line, fd) > 0 && case_count < 64) begin
            op = '0;
            n = $sscanf(line, "%s %h", op, val);
            if (n == 2 && line.getc(0) != "#") begin // Skips comments and blank lines.
                case_op[case_count] = op;
                case_val[case_count] = val;
                case_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_case(input logic [8*12-1:0] op, input logic [31:0] val);
        leaf_pkg::payload_t word;
        case (op)
            "cfg": begin
                send_packet(1'b1, leaf_pkg::LEAF_ID, leaf_pkg::CONFIG_PORT, val);
                exp_route = '{dest_leaf: val[8:4], dest_port: val[3:0]};
            end
            "data": begin
                send_packet(1'b1, leaf_pkg::LEAF_ID, leaf_pkg::DATA_PORT, val);
                word_q.push_back(val);
            end
            "foreign": begin
                send_packet(1'b1, 5'd7, leaf_pkg::CONFIG_PORT, val);
                send_packet(1'b1, 5'd7, leaf_pkg::DATA_PORT, val);
            end
            "novalid": begin
                send_packet(1'b0, leaf_pkg::LEAF_ID, leaf_pkg::CONFIG_PORT, val);
                send_packet(1'b0, leaf_pkg::LEAF_ID, leaf_pkg::DATA_PORT, val);
            end
            "start": begin
                @(negedge clk);
                check_value("out_q.size", out_q.size(), 0); // Nothing may leave before start.
                @(posedge clk);
                ap_start <= 1'b1;
                @(posedge clk);
                ap_start <= 1'b0;
            end
            "resend_on": begin
                @(posedge clk);
                resend <= 1'b1;
            end
            "resend_off": begin
                @(posedge clk);
                resend <= 1'b0;
            end
            "idle": repeat (val) @(posedge clk);
            "expect": begin
                pop_word(word);
                ref_sum = ref_sum + word;
                check_next_output(val);
            end
            "rdata": repeat (val) begin
                random_word(word);
                send_packet(1'b1, leaf_pkg::LEAF_ID, leaf_pkg::DATA_PORT, word);
                word_q.push_back(word);
            end
            "rexpect": repeat (val) begin
                pop_word(word);
                ref_sum = ref_sum + word; // The sum wraps at 32 bits.
                check_next_output(ref_sum);
            end
            "rdrop": repeat (val) pop_word(word); // Lost to a full buffer.
            default: begin
                $display("Unknown operation %0s in the case file.", op);
                $display(">>> FAIL");
                $fatal(1, "Bad case file");
            end
        endcase
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        din_bft = '0;
        resend = 1'b0;
        ap_start = 1'b0;
        cycle_count = 0;
        cycle_limit = 0;
        ref_sum = '0;
        exp_route = '0;
        exp_addr = '0;
        lfsr_state = 32'h64391e15;
        read_cases();
        cycle_limit = 200 * case_count + 1000;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < case_count; i++) begin
            run_case(case_op[i], case_val[i]);
        end
        repeat (20) @(posedge clk);
        @(negedge clk);
        check_value("out_q.size", out_q.size(), 0);
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: bench/leaf_node_cases.txt
# Columns: operation, hex value. The value is a payload for cfg, data, foreign and novalid,
# a count for idle, rdata, rexpect and rdrop, and the next output sum for expect.
idle 5
cfg 00000092
foreign 0000005a
novalid 00000041
data ffffff00
data 00000200
data 12345678
rdata 11
idle 20
start 0
expect ffffff00
expect 00000100
expect 12345778
rexpect d
rdrop 4
foreign 0000007b
novalid 00000031
rdata 6
rexpect 6
rdata 3
resend_on 0
rdata 5
idle 1e
resend_off 0
rexpect 8
data 00000001
rexpect 1
idle a

// File: leaf_node.f
verilog/leaf_pkg.sv
verilog/packet_receiver.sv
verilog/payload_fifo.sv
verilog/user_kernel.sv
verilog/packet_sender.sv
verilog/leaf_node.sv
bench/leaf_node_assert.sv
bench/leaf_node_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module leaf_node_tb \
    -f leaf_node.f > sim.log 2>&1 \
    && ./obj_dir/Vleaf_node_tb >> sim.log 2>&1 \
    || echo "Build or simulation ended with an error"
cat sim.log
grep -qx ">>> PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
